/* dv/rom_loader_ref.svh */
// ********************
// ROM loader reference model
// Region mapping rules, PROM contents model
// and the download addresses under test
// ********************

`ifndef ROM_LOADER_REF_SVH
`define ROM_LOADER_REF_SVH

// Region codes
localparam int RG_CPU    = 0;
localparam int RG_ADPCM  = 1;
localparam int RG_CHAR   = 2;
localparam int RG_SCROLL = 3;
localparam int RG_OBJ    = 4;
localparam int RG_MCU    = 5;
localparam int RG_PROM   = 6;

localparam int N_SDRAM       = 19;
localparam int PROM_PER_BANK = 2;
localparam int N_PROM        = PROM_BANKS * PROM_PER_BANK;

// Expected PROM contents, filled as each bank pulse is seen
dl_data_t prom_model [0:PROM_BANKS-1][0:255];

function automatic int region_of(input dl_addr_t a);
    if (a[21:16] < ADPCM_ADDR[21:16]) return RG_CPU;
    if (a[21:16] < CHAR_ADDR[21:16]) return RG_ADPCM;
    if (a[21:16] < SCRZW_ADDR[21:16]) return RG_CHAR;
    if (a[21:16] < OBJWZ_ADDR[21:16]) return RG_SCROLL;
    if (a[21:16] < MCU_ADDR[21:16]) return RG_OBJ;
    if (a[21:12] < PROM_ADDR[21:12]) return RG_MCU;
    return RG_PROM;
endfunction

function automatic logic is_prom_addr(input dl_addr_t a);
    return region_of(a) == RG_PROM;
endfunction

// Upper half of a scroll or object region
function automatic logic upper_half(input dl_addr_t a);
    logic [3:0] scr_rel;
    logic [4:0] obj_rel;
    scr_rel = a[19:16] - SCRZW_ADDR[19:16];
    obj_rel = a[20:16] - OBJWZ_ADDR[20:16];
    if (region_of(a) == RG_SCROLL) return scr_rel[1];
    return obj_rel >= OBJ_HALF;
endfunction

// 64K word block of a scroll or object byte
function automatic logic [5:0] tile_block(input dl_addr_t a);
    logic [5:0] rel;
    if (region_of(a) == RG_SCROLL) begin
        rel = upper_half(a) ? {2'b00, a[19:16] - SCRXY_ADDR[19:16]}
                            : {2'b00, a[19:16] - SCRZW_ADDR[19:16]};
        return SCR_BASE + rel;
    end
    rel = upper_half(a) ? {1'b0, a[20:16] - OBJXY_ADDR[20:16]}
                        : {1'b0, a[20:16] - OBJWZ_ADDR[20:16]};
    return OBJ_BASE + rel;
endfunction

function automatic dl_addr_t ref_prog_addr(input dl_addr_t a);
    case (region_of(a))
        RG_CPU, RG_ADPCM:  return {1'b0, a[21:1]};
        RG_CHAR:           return {1'b0, a[21:5], a[2:0], a[4]};
        RG_SCROLL, RG_OBJ: return {tile_block(a), a[15:6], a[3:0], a[5:4]};
        RG_MCU:            return {MCU_BLOCK, 3'b000, a[13:1]};
        default:           return a;   // PROM passes through
    endcase
endfunction

function automatic prog_mask_t ref_prog_mask(input dl_addr_t a);
    case (region_of(a))
        RG_CPU, RG_ADPCM, RG_MCU: return {~a[0], a[0]};
        RG_CHAR:                  return {~a[3], a[3]};
        RG_SCROLL, RG_OBJ:        return upper_half(a) ? 2'b01 : 2'b10;
        default:                  return 2'b11;
    endcase
endfunction

// SDRAM bound bytes, even and odd, both halves of scroll and objects
function automatic dl_addr_t sdram_test_addr(input int i);
    case (i)
        0:       return 22'h000000;
        1:       return 22'h012345;
        2:       return 22'h02FFFE;
        3:       return 22'h030001;
        4:       return 22'h04ABCE;
        5:       return 22'h050000;
        6:       return 22'h05A5A9;
        7:       return 22'h05FFF6;
        8:       return 22'h060013;
        9:       return 22'h07BEEF;
        10:      return 22'h080024;
        11:      return 22'h09C0DE;
        12:      return 22'h0A1234;
        13:      return 22'h0DFFFF;
        14:      return 22'h0E4321;
        15:      return 22'h11ABCD;
        16:      return 22'h120000;
        17:      return 22'h123FFF;
        default: return 22'h121A5A;
    endcase
endfunction

// Two distinct bytes in each PROM bank
function automatic dl_addr_t prom_test_addr(input int bank, input int k);
    int         tmp;
    logic [2:0] sel;
    tmp = (k == 0) ? bank * 37 + 5 : 255 - bank;
    sel = bank[2:0];
    return PROM_ADDR + {11'd0, sel, tmp[7:0]};
endfunction

`endif

/* dv/rom_loader_tb.sv */
// ********************
// ROM loader testbench
// Sends loader bytes into every region and checks
// SDRAM mapping, PROM strobes and PROM readback
// ********************

`timescale 1ns/1ns
`default_nettype none

module rom_loader_tb
    import rom_loader_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        downloading;
    dl_addr_t    ioctl_addr;
    dl_data_t    ioctl_data;
    logic        ioctl_wr;
    logic        sdram_clk;
    logic [10:0] prom_rd_addr;
    dl_addr_t    prog_addr;
    dl_data_t    prog_data;
    prog_mask_t  prog_mask;
    logic        prog_we;
    dl_data_t    prom_rd_data;

    integer seed;
    int     writes_sent = 0;
    int     writes_checked = 0;
    int     reads_checked = 0;
    int     cycles = 0;

    // Readback address pipeline, two edges deep
    logic        rd_valid;
    logic        rd_v1;
    logic        rd_v2;
    logic [10:0] rd_a1;
    logic [10:0] rd_a2;

    `include "rom_loader_ref.svh"

    // Reset, idle, six cycles per byte, hold test, readback
    localparam int TEST_CYCLES = 3 + 2 + (N_SDRAM + 2 + N_PROM) * 6 + 3 + N_PROM + 3;
    localparam int CYCLE_LIMIT = 3 * TEST_CYCLES;

    rom_loader_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .sdram_clk    (sdram_clk),
        .prom_rd_addr (prom_rd_addr),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .prog_mask    (prog_mask),
        .prog_we      (prog_we),
        .prom_rd_data (prom_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input dl_addr_t exp, input dl_addr_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input prog_mask_t exp, input prog_mask_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input dl_data_t exp, input dl_data_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_we(input string name, input prom_we_t exp, input prom_we_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            abort_run();
        end
    endtask

    // One byte with a one-cycle strobe, returns once its checks are over
    task automatic send_byte(input dl_addr_t a);
        int rnd;
        rnd = $random(seed);
        ioctl_addr = a;
        ioctl_data = rnd[7:0];
        ioctl_wr = 1'b1;
        writes_sent++;
        @(negedge clk);
        ioctl_wr = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic release_word();
        sdram_clk = 1'b1;   // SDRAM takes the held word
        @(negedge clk);
        sdram_clk = 1'b0;
    endtask

    // Follows each byte from the strobe edge to its results
    always begin : write_check
        dl_addr_t a;
        dl_data_t d;
        prom_we_t hot;
        @(posedge clk);
        if (!reset && ioctl_wr) begin
            a = ioctl_addr;
            d = ioctl_data;
            hot = '0;
            if (is_prom_addr(a)) begin
                hot[a[10:8]] = 1'b1;
            end
            @(posedge clk);
            @(negedge clk);
            check_addr("prog_addr", ref_prog_addr(a), prog_addr);
            check_mask("prog_mask", ref_prog_mask(a), prog_mask);
            check_data("prog_data", d, prog_data);
            check_level("prog_we", !is_prom_addr(a), prog_we);
            check_we("prom_we", '0, dut0.u_mapper.prom_we);
            @(negedge clk);
            check_we("prom_we", hot, dut0.u_mapper.prom_we);   // No pulse for SDRAM bytes
            if (is_prom_addr(a)) begin
                prom_model[a[10:8]][a[7:0]] = d;
            end
            @(negedge clk);
            check_we("prom_we", '0, dut0.u_mapper.prom_we);   // Single cycle only
            writes_checked++;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            rd_v1 <= 1'b0;
            rd_v2 <= 1'b0;
        end else begin
            rd_v1 <= rd_valid;
            rd_v2 <= rd_v1;
        end
        rd_a1 <= prom_rd_addr;
        rd_a2 <= rd_a1;
    end

    always @(negedge clk) begin
        if (rd_v2) begin
            check_data("prom_rd_data", prom_model[rd_a2[10:8]][rd_a2[7:0]], prom_rd_data);
            reads_checked++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not complete within %0d clock cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin : stimulus
        dl_addr_t pa;
        int       b;
        int       k;
        seed = 32'h79c4;
        reset = 1'b1;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ioctl_wr = 1'b0;
        sdram_clk = 1'b0;
        prom_rd_addr = '0;
        rd_valid = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        downloading = 1'b1;

        // Idle after reset
        repeat (2) begin
            @(negedge clk);
            check_level("prog_we", 1'b0, prog_we);
            check_we("prom_we", '0, dut0.u_mapper.prom_we);
        end

        for (b = 0; b < N_SDRAM; b++) begin
            send_byte(sdram_test_addr(b));
            release_word();
        end

        // Word held until the SDRAM takes it
        send_byte(22'h012346);
        repeat (3) begin
            @(negedge clk);
            check_level("prog_we", 1'b1, prog_we);
        end
        release_word();
        check_level("prog_we", 1'b0, prog_we);
        send_byte(22'h0A0040);
        downloading = 1'b0;
        @(negedge clk);
        downloading = 1'b1;
        check_level("prog_we", 1'b0, prog_we);   // Download end drops it too

        for (b = 0; b < PROM_BANKS; b++) begin
            for (k = 0; k < PROM_PER_BANK; k++) begin
                send_byte(prom_test_addr(b, k));
                release_word();
            end
        end

        // Pipelined readback, one address per cycle
        for (b = 0; b < PROM_BANKS; b++) begin
            for (k = 0; k < PROM_PER_BANK; k++) begin
                pa = prom_test_addr(b, k);
                prom_rd_addr = pa[10:0];
                rd_valid = 1'b1;
                @(negedge clk);
            end
        end
        rd_valid = 1'b0;
        repeat (3) @(negedge clk);

        if (writes_checked != writes_sent || reads_checked != N_PROM) begin
            $display("Not every result was checked: %0d of %0d writes, %0d of %0d reads",
                     writes_checked, writes_sent, reads_checked, N_PROM);
            abort_run();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
verilog/rom_loader_pkg.sv
verilog/download_mapper.sv
verilog/prom_bank.sv
verilog/prom_read_mux.sv
verilog/rom_loader_top.sv
dv/rom_loader_tb.sv

/* verilog/download_mapper.sv */
// ********************
// Download mapper
// Classifies each loader byte by region, remaps it
// to an SDRAM word address with byte mask, and
// turns PROM bytes into one-hot bank write pulses
// ********************

`timescale 1ns/1ns
`default_nettype none

module download_mapper
    import rom_loader_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        downloading,
    input  wire dl_addr_t   ioctl_addr,
    input  wire dl_data_t   ioctl_data,
    input  wire        ioctl_wr,
    input  wire        sdram_clk,
    output dl_addr_t   prog_addr,
    output dl_data_t   prog_data,
    output prog_mask_t prog_mask,
    output logic       prog_we,
    output prom_we_t   prom_we,
    output prom_addr_t prom_wr_addr,
    output dl_data_t   prom_wr_data
);

    // Input stage
    logic     wr_q;
    dl_addr_t addr_q;
    dl_data_t data_q;

    // Decode of the registered address
    logic [5:0]  region;
    logic [3:0]  scr_off;
    logic [3:0]  scr_off_top;
    logic        scr_top;
    logic [4:0]  obj_off;
    logic [4:0]  obj_off_top;
    logic        obj_top;
    logic [15:0] tile_low;
    dl_addr_t    word_addr;
    prog_mask_t  byte_mask;

    dl_addr_t   map_addr;
    prog_mask_t map_mask;
    logic       map_prom;

    // PROM byte waiting for its bank pulse
    logic       prom_pend;
    prom_sel_t  pend_sel;
    prom_addr_t pend_addr;
    dl_data_t   pend_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= ioctl_wr;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= ioctl_addr;
        data_q <= ioctl_data;
    end

    assign region      = addr_q[21:16];
    assign scr_off     = addr_q[19:16] - SCRZW_ADDR[19:16];
    assign scr_off_top = addr_q[19:16] - SCRXY_ADDR[19:16];
    assign scr_top     = scr_off[1];                // Every other pair of blocks
    assign obj_off     = addr_q[20:16] - OBJWZ_ADDR[20:16];
    assign obj_off_top = addr_q[20:16] - OBJXY_ADDR[20:16];
    assign obj_top     = obj_off >= OBJ_HALF;
    assign tile_low    = {addr_q[15:6], addr_q[3:0], addr_q[5:4]};
    assign word_addr   = {1'b0, addr_q[21:1]};
    assign byte_mask   = {~addr_q[0], addr_q[0]};   // Even bytes go to the low half

    always_comb begin
        map_addr = addr_q;
        map_mask = 2'b11;
        map_prom = 1'b0;
        if (region < ADPCM_ADDR[21:16]) begin           // CPU and sound
            map_addr = word_addr;
            map_mask = byte_mask;
        end else if (region < CHAR_ADDR[21:16]) begin   // ADPCM
            map_addr = word_addr;
            map_mask = byte_mask;
        end else if (region < SCRZW_ADDR[21:16]) begin  // Characters
            map_addr = {1'b0, addr_q[21:5], addr_q[2:0], addr_q[4]};
            map_mask = {~addr_q[3], addr_q[3]};
        end else if (region < OBJWZ_ADDR[21:16]) begin  // Scroll
            map_addr = {SCR_BASE + {2'b00, scr_top ? scr_off_top : scr_off}, tile_low};
            map_mask = scr_top ? 2'b01 : 2'b10;
        end else if (region < MCU_ADDR[21:16]) begin    // Objects
            map_addr = {OBJ_BASE + {1'b0, obj_top ? obj_off_top : obj_off}, tile_low};
            map_mask = obj_top ? 2'b01 : 2'b10;
        end else if (addr_q[21:12] < PROM_ADDR[21:12]) begin
            // MCU code sits in its own SDRAM block
            map_addr = {MCU_BLOCK, 3'b000, addr_q[13:1]};
            map_mask = byte_mask;
        end else begin
            map_prom = 1'b1;    // Kept on chip, address passes through
        end
    end

    // SDRAM write level, held until the word is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we   <= 1'b0;
            prom_pend <= 1'b0;
        end else begin
            prom_pend <= 1'b0;
            if (wr_q) begin
                prog_we   <= ~map_prom;
                prom_pend <= map_prom;
            end else if (!ioctl_wr && (sdram_clk || !downloading)) begin
                prog_we <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_q) begin
            prog_addr <= map_addr;
            prog_data <= data_q;
            prog_mask <= map_mask;
            if (map_prom) begin
                pend_sel  <= addr_q[10:8];
                pend_addr <= addr_q[7:0];
                pend_data <= data_q;
            end
        end
    end

    // Bank pulse one cycle after the pending flag
    always_ff @(posedge clk) begin
        if (reset) begin
            prom_we <= '0;
        end else if (prom_pend) begin
            prom_we <= prom_we_t'(1) << pend_sel;
        end else begin
            prom_we <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (prom_pend) begin
            prom_wr_addr <= pend_addr;  // Held steady while the bank writes
            prom_wr_data <= pend_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/prom_bank.sv */
// ********************
// PROM bank
// 256 byte on-chip store with a write pulse
// and a registered read port
// ********************

`timescale 1ns/1ns
`default_nettype none

module prom_bank
    import rom_loader_pkg::*;
(
    input  wire             clk,
    input  wire             we,
    input  wire prom_addr_t wr_addr,
    input  wire dl_data_t   wr_data,
    input  wire prom_addr_t rd_addr,
    output dl_data_t        rd_data
);

    // One entry per bank byte
    dl_data_t mem [0:(1 << $bits(prom_addr_t)) - 1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered output maps onto block RAM
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* verilog/prom_read_mux.sv */
// ********************
// PROM read multiplexer
// Picks the addressed bank's byte and registers it
// ********************

`timescale 1ns/1ns
`default_nettype none

module prom_read_mux
    import rom_loader_pkg::*;
(
    input  wire clk,
    input  wire reset,
    input  wire prom_sel_t                   rd_sel,
    input  wire dl_data_t [PROM_BANKS-1:0]  bank_data,
    output dl_data_t                         rd_data
);

    prom_sel_t sel_q;   // Lines up with the bank read register

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_q   <= '0;
            rd_data <= '0;
        end else begin
            sel_q   <= rd_sel;
            rd_data <= bank_data[sel_q];
        end
    end

endmodule

`default_nettype wire

/* verilog/rom_loader_pkg.sv */
// ********************
// ROM loader package
// Region bases, SDRAM block offsets and
// the vector types shared by the download path
// ********************

`default_nettype none

package rom_loader_pkg;

    // Download stream and SDRAM programming
    typedef logic [21:0] dl_addr_t;     // Byte address from the loader, word address to SDRAM
    typedef logic [7:0]  dl_data_t;     // One download byte
    typedef logic [1:0]  prog_mask_t;   // Active low, bit 1 is the upper byte

    // PROM banks
    typedef logic [2:0]  prom_sel_t;    // Bank index
    typedef logic [7:0]  prom_addr_t;   // Byte inside a bank
    typedef logic [7:0]  prom_we_t;     // One write pulse per bank

    localparam int PROM_BANKS = 8;

    // Start of each region in the download stream
    localparam dl_addr_t ADPCM_ADDR = 22'h30000;
    localparam dl_addr_t CHAR_ADDR  = 22'h50000;
    localparam dl_addr_t SCRZW_ADDR = 22'h60000;  // Scroll, lower half
    localparam dl_addr_t SCRXY_ADDR = 22'h80000;  // Scroll, upper half
    localparam dl_addr_t OBJWZ_ADDR = 22'hA0000;  // Objects, lower half
    localparam dl_addr_t OBJXY_ADDR = 22'hE0000;  // Objects, upper half
    localparam dl_addr_t MCU_ADDR   = 22'h120000;
    localparam dl_addr_t PROM_ADDR  = 22'h124000;

    // SDRAM placement in 64K word blocks
    localparam logic [5:0] SCR_BASE  = 6'd6;
    localparam logic [5:0] OBJ_BASE  = 6'd8;
    localparam logic [4:0] OBJ_HALF  = 5'd4;     // Blocks per object half
    localparam logic [5:0] MCU_BLOCK = 6'hC;     // Upper field of MCU words

endpackage

`default_nettype wire

/* verilog/rom_loader_top.sv */
// ********************
// ROM loader top
// Download mapper feeding eight PROM banks,
// with a read multiplexer for PROM readback
// ********************

`timescale 1ns/1ns
`default_nettype none

module rom_loader_top
    import rom_loader_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              downloading,
    input  wire dl_addr_t    ioctl_addr,
    input  wire dl_data_t    ioctl_data,
    input  wire              ioctl_wr,
    input  wire              sdram_clk,
    input  wire [10:0]       prom_rd_addr,  // Bank in 10:8, byte in 7:0
    output wire dl_addr_t    prog_addr,
    output wire dl_data_t    prog_data,
    output wire prog_mask_t  prog_mask,
    output wire              prog_we,
    output wire dl_data_t    prom_rd_data
);

    wire prom_we_t                   prom_we;
    wire prom_addr_t                 prom_wr_addr;
    wire dl_data_t                   prom_wr_data;
    wire dl_data_t [PROM_BANKS-1:0] bank_rd;

    download_mapper u_mapper (
        .clk          (clk),
        .reset        (reset),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .sdram_clk    (sdram_clk),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .prog_mask    (prog_mask),
        .prog_we      (prog_we),
        .prom_we      (prom_we),
        .prom_wr_addr (prom_wr_addr),
        .prom_wr_data (prom_wr_data)
    );

    // Every bank sees the same write bus and read address
    for (genvar i = 0; i < PROM_BANKS; i++) begin : g_bank
        prom_bank u_bank (
            .clk     (clk),
            .we      (prom_we[i]),
            .wr_addr (prom_wr_addr),
            .wr_data (prom_wr_data),
            .rd_addr (prom_rd_addr[7:0]),
            .rd_data (bank_rd[i])
        );
    end

    prom_read_mux u_rd_mux (
        .clk       (clk),
        .reset     (reset),
        .rd_sel    (prom_rd_addr[10:8]),
        .bank_data (bank_rd),
        .rd_data   (prom_rd_data)
    );

endmodule

`default_nettype wire
